/* adc_serial_reader.sv */
// Generates sclk and chip select for the ADC and captures one 12-bit sample per frame.
// sdi_adc is sampled directly on the rising sclk with no synchronizer.
module adc_serial_reader import lab4_pkg::*; #(
  parameter int SCLK_HALF = 13  // clk cycles per half serial period
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    sdi_adc,
  output logic    sclk,
  output logic    cs_adc,        // Active low
  output logic    sdo_adc,
  output logic    sclk_fall,     // Marks the clk edge where sclk falls
  output logic    frame_start,   // Marks the clk edge where cs_adc falls
  output logic    sample_valid,
  output sample_t sample
);

  localparam int PERIODS = FRAME_BITS + IDLE_BITS;
  localparam int HALF_W  = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
  localparam int BIT_W   = $clog2(PERIODS);
  localparam int SMP_W   = $bits(sample_t);

  logic [HALF_W-1:0] half_cnt;  // clk cycles in current half period
  logic [BIT_W-1:0]  bit_cnt;   // Serial period within the frame
  logic [BIT_W-1:0]  next_bit;
  logic              half_done;
  logic              sclk_rise;
  logic              last_rise; // Rising edge of the final data bit
  sample_t           shift_in;

  // ============================================================
  // Edge strobes
  // ============================================================
  assign half_done   = (half_cnt == HALF_W'(SCLK_HALF - 1));
  assign sclk_fall   = half_done & sclk;
  assign sclk_rise   = half_done & ~sclk;
  assign next_bit    = (bit_cnt == BIT_W'(PERIODS - 1)) ? '0 : bit_cnt + 1'b1;
  assign frame_start = sclk_fall & (next_bit == '0);
  assign last_rise   = sclk_rise & ~cs_adc & (bit_cnt == BIT_W'(FRAME_BITS - 1));

  // ============================================================
  // Clock, chip select and command
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      half_cnt     <= '0;
      sclk         <= 1'b0;
      bit_cnt      <= BIT_W'(PERIODS - 1);  // Start in the idle period
      cs_adc       <= 1'b1;
      sdo_adc      <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= last_rise;

      if (half_done) begin
        half_cnt <= '0;
        sclk     <= ~sclk;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end

      // Everything on the ADC side moves after the falling edge
      if (sclk_fall) begin
        bit_cnt <= next_bit;
        cs_adc  <= (next_bit >= BIT_W'(FRAME_BITS));
        if (next_bit < BIT_W'(CMD_W))
          sdo_adc <= ADC_CMD[CMD_W - 1 - int'(next_bit)];
        else
          sdo_adc <= 1'b0;  // Data phase, ADC ignores din
      end
    end
  end

  // Data path, bits 0-3 fall off the top of the shifter
  always_ff @(posedge clk) begin
    if (sclk_rise && !cs_adc) begin
      shift_in <= {shift_in[SMP_W-2:0], sdi_adc};
    end
    if (last_rise) begin
      sample <= {shift_in[SMP_W-2:0], sdi_adc};
    end
  end

endmodule

/* dac_serial_writer.sv */
// Shares sclk with the ADC reader, so cs_dac tracks cs_adc edge for edge.
module dac_serial_writer import lab4_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    frame_start,
  input  logic    sclk_fall,
  input  sample_t out_sample,
  output logic    cs_dac,      // Active low
  output logic    sdo_dac
);

  localparam int WORD_W = CMD_W + $bits(sample_t);
  localparam int CNT_W  = $clog2(FRAME_BITS);

  logic [WORD_W-1:0] load_word;
  logic [WORD_W-1:0] shift_out;  // Bits still to send, MSB next
  logic [CNT_W-1:0]  bit_cnt;    // Bits already on the wire
  logic              last_bit;

  assign load_word = {DAC_CMD, out_sample};
  assign last_bit  = (bit_cnt == CNT_W'(FRAME_BITS - 1));

  // ============================================================
  // Frame control
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      cs_dac  <= 1'b1;
      sdo_dac <= 1'b0;
      bit_cnt <= '0;
    end else if (frame_start) begin
      cs_dac  <= 1'b0;
      sdo_dac <= load_word[WORD_W-1];  // First bit out with the falling edge
      bit_cnt <= '0;
    end else if (sclk_fall && !cs_dac) begin
      if (last_bit) begin
        cs_dac  <= 1'b1;  // DAC latches the word here
        sdo_dac <= 1'b0;
      end else begin
        sdo_dac <= shift_out[WORD_W-1];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Shifter
  always_ff @(posedge clk) begin
    if (frame_start)
      shift_out <= {load_word[WORD_W-2:0], 1'b0};
    else if (sclk_fall && !cs_dac)
      shift_out <= {shift_out[WORD_W-2:0], 1'b0};
  end

endmodule

/* lab4.f */
lab4_pkg.sv
adc_serial_reader.sv
quadrature_decoder.sv
sample_delay_line.sv
dac_serial_writer.sv
wirewithfeatures.sv
lab4.sv
wirewithfeatures_asserts.sv
tb_lab4.sv

/* lab4.sv */
// Board shell for the 50 MHz lab board with the ADC, DAC and encoder on GPIO0.
// HEX digits are blanked. GPIO1 and the clock-out pins are not used.
module lab4 #(
  parameter int SCLK_HALF = 13,  // 50 MHz / 26, just under 2 MHz sclk
  parameter int DEPTH     = 8
) (
  input  logic        CLOCK_50,
  input  logic        CLOCK_50_2,
  input  logic [2:0]  BUTTON,        // Active low
  input  logic [9:0]  SW,
  output logic [6:0]  HEX0_D,
  output logic        HEX0_DP,
  output logic [6:0]  HEX1_D,
  output logic        HEX1_DP,
  output logic [6:0]  HEX2_D,
  output logic        HEX2_DP,
  output logic [6:0]  HEX3_D,
  output logic        HEX3_DP,
  output logic [9:0]  LEDG,
  input  logic [1:0]  GPIO0_CLKIN,
  output logic [1:0]  GPIO0_CLKOUT,
  inout  wire  [31:0] GPIO0_D,
  input  logic [1:0]  GPIO1_CLKIN,
  output logic [1:0]  GPIO1_CLKOUT,
  inout  wire  [31:0] GPIO1_D
);

  logic sclk, cs_dac, sdo_dac, cs_adc, sdo_adc;
  logic reset;

  // ============================================================
  // Pin map
  // ============================================================
  assign {GPIO0_D[31:15], GPIO0_D[10:9], GPIO0_D[3:0]} = 'z;  // Unused, float
  assign GPIO1_D      = 'z;
  assign GPIO0_CLKOUT = 2'b00;
  assign GPIO1_CLKOUT = 2'b00;

  assign GPIO0_D[8]  = cs_dac;
  assign GPIO0_D[7]  = sdo_dac;
  assign GPIO0_D[6]  = sclk;
  assign GPIO0_D[14] = cs_adc;
  assign GPIO0_D[12] = sdo_adc;
  assign GPIO0_D[11] = sclk;  // Same clock to both converters

  assign reset = ~BUTTON[0];
  assign LEDG  = {7'b0, SW[1], SW[0], reset};  // en, mode, reset

  // Segments are active low, all ones is dark
  assign {HEX0_D, HEX1_D, HEX2_D, HEX3_D}     = {4{7'h7F}};
  assign {HEX0_DP, HEX1_DP, HEX2_DP, HEX3_DP} = 4'hF;

  wirewithfeatures #(.SCLK_HALF(SCLK_HALF), .DEPTH(DEPTH)) top (
    .clk(CLOCK_50), .reset(reset), .en(SW[1]), .mode(SW[0]),
    .encA(GPIO0_D[5]), .encB(GPIO0_D[4]), .sdi_adc(GPIO0_D[13]),
    .sclk(sclk), .sdo_dac(sdo_dac), .sdo_adc(sdo_adc),
    .cs_dac(cs_dac), .cs_adc(cs_adc)
  );

endmodule

/* lab4_pkg.sv */
// Shared sample type, frame constants and converter command bits.
// The command bit values assume an MCP3002-style ADC and an MCP4921-style DAC.
package lab4_pkg;

  // ============================================================
  // Sample format
  // ============================================================
  typedef logic [11:0] sample_t;  // Unsigned converter code

  localparam sample_t MIDSCALE = 12'd2048;  // Output level when muted

  // ============================================================
  // Serial frame
  // ============================================================
  localparam int FRAME_BITS = 16;  // sclk periods with chip select low
  localparam int IDLE_BITS  = 1;   // sclk periods with chip select high
  localparam int CMD_W      = 4;   // Command bits leading each frame

  // ADC command sent MSB first on sdo_adc
  // Start, single-ended, channel 0, MSB-first output
  localparam logic [CMD_W-1:0] ADC_CMD = 4'b1101;

  // DAC configuration nibble ahead of the 12 data bits
  // Channel A, buffered ref, gain 1, output active
  localparam logic [CMD_W-1:0] DAC_CMD = 4'b0111;

  // ============================================================
  // Echo control
  // ============================================================
  localparam int DELAY_MAX = 7;  // Extra frames of echo delay at most

endpackage

/* quadrature_decoder.sv */
// Encoder inputs are synchronized but not debounced. One detent is four valid transitions.
module quadrature_decoder import lab4_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       enc_a,
  input  logic       enc_b,
  output logic [2:0] delay_sel
);

  logic [1:0]        a_sync;   // Two-stage synchronizer
  logic [1:0]        b_sync;
  logic [1:0]        cur_ab;
  logic [1:0]        prev_ab;
  logic              fwd;      // A leading B
  logic              bwd;      // B leading A
  logic signed [2:0] sub_cnt;  // Partial detent, -3 to 3

  assign cur_ab = {a_sync[1], b_sync[1]};

  // Gray-code transition table, double steps ignored
  always_comb begin
    fwd = 1'b0;
    bwd = 1'b0;
    case ({prev_ab, cur_ab})
      4'b0010, 4'b1011, 4'b1101, 4'b0100: fwd = 1'b1;
      4'b1000, 4'b1110, 4'b0111, 4'b0001: bwd = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      a_sync    <= '0;
      b_sync    <= '0;
      prev_ab   <= '0;
      sub_cnt   <= '0;
      delay_sel <= '0;
    end else begin
      a_sync  <= {a_sync[0], enc_a};
      b_sync  <= {b_sync[0], enc_b};
      prev_ab <= cur_ab;
      if (fwd) begin
        if (sub_cnt == 3'sd3) begin
          sub_cnt <= '0;
          if (delay_sel < 3'(DELAY_MAX)) delay_sel <= delay_sel + 1'b1;  // Clamp high
        end else begin
          sub_cnt <= sub_cnt + 3'sd1;
        end
      end else if (bwd) begin
        if (sub_cnt == -3'sd3) begin
          sub_cnt <= '0;
          if (delay_sel != '0) delay_sel <= delay_sel - 1'b1;  // Clamp at zero
        end else begin
          sub_cnt <= sub_cnt - 3'sd1;
        end
      end
    end
  end

endmodule

/* sample_delay_line.sv */
// DEPTH must be a power of two and larger than DELAY_MAX.
// Controls take effect on the next sample, not between samples.
module sample_delay_line import lab4_pkg::*; #(
  parameter int DEPTH = 8  // Stored samples
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       sample_valid,
  input  sample_t    sample,
  input  logic       en,          // Low mutes to midscale
  input  logic       mode,        // High selects echo
  input  logic [2:0] delay_sel,   // Extra frames of echo delay
  output sample_t    out_sample
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int SMP_W = $bits(sample_t);

  sample_t          mem [DEPTH];  // Circular history
  logic [PTR_W-1:0] wr_ptr;       // Next slot to write
  logic [PTR_W-1:0] tap_ptr;
  sample_t          tap;
  logic [SMP_W:0]   echo_sum;     // One extra bit for the carry

  // ============================================================
  // Tap read
  // ============================================================
  // wr_ptr-1 holds the previous frame, delay_sel reaches further back
  assign tap_ptr  = wr_ptr - PTR_W'(delay_sel) - 1'b1;
  assign tap      = mem[tap_ptr];
  assign echo_sum = {1'b0, sample} + {1'b0, tap};

  // ============================================================
  // Write and output select
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= MIDSCALE;  // Older taps read as silence
      end
      wr_ptr     <= '0;
      out_sample <= MIDSCALE;
    end else if (sample_valid) begin
      mem[wr_ptr] <= sample;  // Tap read above uses the old contents
      wr_ptr      <= wr_ptr + 1'b1;
      if (!en)
        out_sample <= MIDSCALE;
      else if (!mode)
        out_sample <= sample;  // Straight through
      else
        out_sample <= echo_sum[SMP_W:1];  // Floor of the mean
    end
  end

endmodule

/* tb_lab4.sv */
// Runs lab4 with a 4-clk serial period. Models the ADC and encoder on GPIO0 and captures the DAC.
// Expected words follow the sample list and the controls of each frame, one frame late.
module tb_lab4 import lab4_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SCLK_HALF  = 2;
  localparam int FRAME_CLKS = (FRAME_BITS + IDLE_BITS) * 2 * SCLK_HALF;  // 68 clk
  localparam int NF         = 48;  // Sample list length covering every test
  localparam int NT         = 5;
  localparam int TIMEOUT_NS = 3 * (NF + 2) * FRAME_CLKS * 4 / 2;

  logic        clk;
  logic        clk_2;
  logic [2:0]  button;
  logic [9:0]  sw;                  // SW[1] en, SW[0] mode
  logic [1:0]  clkin0;
  logic [1:0]  clkin1;
  wire  [31:0] gpio0;
  wire  [31:0] gpio1;
  wire  [6:0]  hex0;
  wire  [6:0]  hex1;
  wire  [6:0]  hex2;
  wire  [6:0]  hex3;
  wire  [3:0]  hex_dp;
  wire  [9:0]  ledg;
  wire  [1:0]  clkout0;
  wire  [1:0]  clkout1;
  logic        drive_io;
  logic        sdi;
  logic [1:0]  enc_ab;              // {A, B}
  logic        frame_go;            // One clk after each ADC frame start

  string   names [NT] = '{"reset", "echo_delay0", "straight", "mute", "encoder"};
  int      enc_steps [12] = '{3, 0, 3, 0, 3, 0, -4, 0, -5, 0, 2, 0};  // Detents per frame
  sample_t smp [NF];
  logic    en_f [NF];
  logic    mode_f [NF];
  logic    chk_f [NF];              // Low where the encoder moved
  int      dly_f [NF];
  int      tid_f [NF];              // Owning test or -1
  int      checks [NT];
  int      errs [NT];
  int      seed, adc_n, adc_bit, dac_bits, dac_k, frames_run, exp_dly, total_chk, total_err;
  logic    sclk_q, cs_q, dsclk_q;
  logic [15:0] adc_frame;
  logic [15:0] dac_word;
  logic [3:0]  cmd_bits;

  // Pins as lab4 maps them
  wire adc_sclk = gpio0[11];
  wire adc_cs   = gpio0[14];
  wire adc_sdo  = gpio0[12];
  wire dac_sclk = gpio0[6];
  wire dac_sdo  = gpio0[7];
  wire dac_cs   = gpio0[8];

  assign gpio0[13] = drive_io ? sdi : 1'bz;
  assign gpio0[5]  = drive_io ? enc_ab[1] : 1'bz;
  assign gpio0[4]  = drive_io ? enc_ab[0] : 1'bz;

  lab4 #(.SCLK_HALF(SCLK_HALF), .DEPTH(8)) uut (
    .CLOCK_50(clk), .CLOCK_50_2(clk_2), .BUTTON(button), .SW(sw),
    .HEX0_D(hex0), .HEX0_DP(hex_dp[0]), .HEX1_D(hex1), .HEX1_DP(hex_dp[1]),
    .HEX2_D(hex2), .HEX2_DP(hex_dp[2]), .HEX3_D(hex3), .HEX3_DP(hex_dp[3]),
    .LEDG(ledg),
    .GPIO0_CLKIN(clkin0), .GPIO0_CLKOUT(clkout0), .GPIO0_D(gpio0),
    .GPIO1_CLKIN(clkin1), .GPIO1_CLKOUT(clkout1), .GPIO1_D(gpio1)
  );

  // ============================================================
  // Compare tasks and reference model
  // ============================================================
  task automatic check_word(input int t, input logic [15:0] exp, input logic [15:0] act);
    checks[t]++;
    if (act !== exp) begin
      errs[t]++;
      $display("Fail %s: expected %h, actual %h", names[t], exp, act);
    end
  endtask

  task automatic check_sample(input int t, input sample_t exp, input sample_t act);
    checks[t]++;
    if (act !== exp) begin
      errs[t]++;
      $display("Fail %s: expected %0d, actual %0d", names[t], exp, act);
    end
  endtask

  // Output for the sample of frame n as heard in DAC frame n+1
  function automatic sample_t expect_out(input int n);
    sample_t     tap;
    logic [12:0] sum;
    tap = (n - 1 - dly_f[n] < 0) ? MIDSCALE : smp[n - 1 - dly_f[n]];  // Fresh history is midscale
    sum = {1'b0, smp[n]} + {1'b0, tap};
    if (!en_f[n]) return MIDSCALE;
    else if (!mode_f[n]) return smp[n];
    else return sum[12:1];  // Floor of the mean
  endfunction

  task automatic compare_dac(input int k, input logic [15:0] w);
    int n;
    int t;
    n = k - 1;
    t = (k == 0) ? 0 : (n < NF) ? tid_f[n] : -1;  // Word 0 carries the reset value
    if (t < 0) return;
    if (k == 0 || chk_f[n]) begin
      check_word(t, 16'(DAC_CMD), 16'(w[15:12]));
      check_sample(t, (k == 0) ? MIDSCALE : expect_out(n), w[11:0]);
    end
    if (k == 0 || n + 1 >= NF || tid_f[n + 1] != t)
      $display("%-12s done: %0d checks, %0d errors", names[t], checks[t], errs[t]);
  endtask

  // ============================================================
  // Stimulus helpers
  // ============================================================
  task automatic step_detent(input logic up);
    logic [7:0] pat;
    pat = up ? 8'b10_11_01_00 : 8'b01_11_10_00;  // Four {A,B} states per detent
    for (int i = 0; i < 4; i++) begin
      enc_ab <= pat[7 - 2*i -: 2];
      repeat (2) @(posedge clk);
    end
    if (up && exp_dly < DELAY_MAX) exp_dly++;   // Clamped like the knob
    else if (!up && exp_dly > 0) exp_dly--;
  endtask

  // Sets the controls early in the next ADC frame and records them
  task automatic run_frame(input int t, input logic en_v, input logic mode_v, input int steps);
    int n;
    @(posedge clk iff frame_go);
    n = adc_n;
    sw[1] <= en_v;
    sw[0] <= mode_v;
    tid_f[n]  = t;
    en_f[n]   = en_v;
    mode_f[n] = mode_v;
    chk_f[n]  = (steps == 0);  // Knob frames are settling
    @(posedge clk);
    check_word(t, 16'({en_v, mode_v, 1'b0}), 16'(ledg));  // Switch LEDs lit, reset LED dark
    for (int i = 0; i < ((steps < 0) ? -steps : steps); i++) step_detent(steps > 0);
    dly_f[n]   = exp_dly;
    frames_run = n + 1;
  endtask

  // ============================================================
  // Clock, converter models and watchdog
  // ============================================================
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ADC model puts a new bit out after each falling sclk and checks the command nibble
  always @(posedge clk) begin
    frame_go <= 1'b0;
    if (sclk_q && !adc_sclk && !adc_cs) begin
      if (cs_q) begin  // cs fell with this edge
        adc_n++;
        adc_bit   = 0;
        adc_frame = {4'b1010, (adc_n < NF) ? smp[adc_n] : MIDSCALE};  // Lead bits are junk
        frame_go <= 1'b1;
      end
      sdi <= adc_frame[15 - adc_bit];
      if (adc_bit < 4) cmd_bits[3 - adc_bit] = adc_sdo;
      if (adc_bit == 3 && adc_n < NF && tid_f[adc_n] >= 0)
        check_word(tid_f[adc_n], 16'(ADC_CMD), 16'(cmd_bits));
      adc_bit++;
    end
    sclk_q = adc_sclk;
    cs_q   = adc_cs;
  end

  // DAC capture on rising sclk
  always @(posedge clk) begin
    if (!dsclk_q && dac_sclk && !dac_cs) begin
      if (adc_n < 0) begin
        errs[0]++;
        $display("Error: DAC shifted a bit before the first ADC frame");
      end
      dac_word = {dac_word[14:0], dac_sdo};
      dac_bits++;
      if (dac_bits == FRAME_BITS) begin
        compare_dac(dac_k, dac_word);
        dac_k++;
        dac_bits = 0;
      end
    end
    dsclk_q = dac_sclk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: %0d DAC words seen, %0d expected", dac_k, frames_run + 1);
    $display("TEST FAIL");
    $finish;
  end

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    clk_2    = 1'b0;
    button   = 3'b110;  // BUTTON[0] low holds reset
    sw       = '0;
    clkin0   = '0;
    clkin1   = '0;
    drive_io = 1'b1;
    sdi      = 1'b0;
    enc_ab   = 2'b00;
    frame_go = 1'b0;
    sclk_q   = 1'b0;
    cs_q     = 1'b1;
    dsclk_q  = 1'b0;
    adc_n    = -1;
    adc_bit  = 0;
    dac_bits = 0;
    dac_k    = 0;
    exp_dly  = 0;
    frames_run = 0;
    seed     = 82667;
    for (int i = 0; i < NF; i++) begin
      smp[i]   = sample_t'($random(seed));
      tid_f[i] = -1;
      chk_f[i] = 1'b1;
    end
    for (int t = 0; t < NT; t++) begin
      checks[t] = 0;
      errs[t]   = 0;
    end

    repeat (8) @(posedge clk);
    button[0] <= 1'b1;
    // sclk, sdo_adc, sdo_dac low and both chip selects high
    check_word(0, 16'h0003, {11'd0, dac_sclk, adc_sdo, dac_sdo, adc_cs, dac_cs});
    check_word(0, 16'h3FFF, {2'b00, hex0, hex1});  // Segments dark
    check_word(0, 16'h3FFF, {2'b00, hex2, hex3});
    check_word(0, 16'h000F, {12'd0, hex_dp});
    check_word(0, 16'h0001, {6'd0, ledg});  // Only the reset LED lit
    check_word(0, 16'h0000, {12'd0, clkout0, clkout1});

    repeat (6) run_frame(1, 1'b1, 1'b1, 0);   // Echo at delay 0 on a fresh history
    repeat (20) run_frame(2, 1'b1, 1'b0, 0);
    repeat (6) run_frame(3, 1'b0, 1'b1, 0);   // Muted with echo selected
    foreach (enc_steps[i]) run_frame(4, 1'b1, 1'b1, enc_steps[i]);

    wait (dac_k >= frames_run + 1);
    total_chk = 0;
    total_err = uut.top.u_asserts.err_cnt;
    for (int t = 0; t < NT; t++) begin
      total_chk += checks[t];
      total_err += errs[t];
    end
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             total_chk, total_err, uut.top.u_asserts.err_cnt);
    if (total_err == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* wirewithfeatures.sv */
// ADC to DAC core with mute, echo and encoder-selected delay.
// Fixed-rate flow with one sample per serial frame and no back-pressure.
module wirewithfeatures import lab4_pkg::*; #(
  parameter int SCLK_HALF = 13,  // clk cycles per half serial period
  parameter int DEPTH     = 8    // Echo history entries
) (
  input  logic clk,
  input  logic reset,
  input  logic en,
  input  logic mode,
  input  logic encA,
  input  logic encB,
  input  logic sdi_adc,
  output logic sclk,
  output logic sdo_dac,
  output logic sdo_adc,
  output logic cs_dac,
  output logic cs_adc
);

  logic       sclk_fall;
  logic       frame_start;
  logic       sample_valid;
  sample_t    sample;
  sample_t    out_sample;
  logic [2:0] delay_sel;

  // ============================================================
  // Producer, control and buffer
  // ============================================================
  adc_serial_reader #(.SCLK_HALF(SCLK_HALF)) u_reader (
    .clk(clk), .reset(reset), .sdi_adc(sdi_adc),
    .sclk(sclk), .cs_adc(cs_adc), .sdo_adc(sdo_adc),
    .sclk_fall(sclk_fall), .frame_start(frame_start),
    .sample_valid(sample_valid), .sample(sample)
  );

  quadrature_decoder u_decoder (
    .clk(clk), .reset(reset), .enc_a(encA), .enc_b(encB), .delay_sel(delay_sel)
  );

  sample_delay_line #(.DEPTH(DEPTH)) u_delay (
    .clk(clk), .reset(reset), .sample_valid(sample_valid), .sample(sample),
    .en(en), .mode(mode), .delay_sel(delay_sel), .out_sample(out_sample)
  );

  // Consumer, one frame behind the capture
  dac_serial_writer u_writer (
    .clk(clk), .reset(reset), .frame_start(frame_start), .sclk_fall(sclk_fall),
    .out_sample(out_sample), .cs_dac(cs_dac), .sdo_dac(sdo_dac)
  );

endmodule

/* wirewithfeatures_asserts.sv */
// Bound into wirewithfeatures. Assumes the idle gap is one serial period.
module wirewithfeatures_asserts #(
  parameter int SCLK_HALF = 13
) (
  input logic clk,
  input logic reset,
  input logic cs_adc,
  input logic cs_dac,
  input logic frame_start,
  input logic sample_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IDLE_CLKS = 2 * SCLK_HALF;  // One sclk period

  int err_cnt = 0;  // Failed assertions so far

  // Chip select high for exactly the idle period
  idle_gap: assert property (@(posedge clk) disable iff (reset)
    $rose(cs_adc) |-> cs_adc [*IDLE_CLKS] ##1 !cs_adc)
    else begin
      err_cnt++;
      $error("chip select idle gap is not one serial period");
    end

  cs_match: assert property (@(posedge clk) disable iff (reset) cs_adc == cs_dac)
    else begin
      err_cnt++;
      $error("cs_adc and cs_dac differ");
    end

  // One sample strobe between frame starts
  one_sample: assert property (@(posedge clk) disable iff (reset)
    frame_start |=> (!frame_start throughout sample_valid [->1])
                    ##1 (!sample_valid throughout frame_start [->1]))
    else begin
      err_cnt++;
      $error("sample_valid not seen exactly once in a frame");
    end

endmodule

bind wirewithfeatures wirewithfeatures_asserts #(.SCLK_HALF(SCLK_HALF)) u_asserts (
  .clk(clk), .reset(reset), .cs_adc(cs_adc), .cs_dac(cs_dac),
  .frame_start(frame_start), .sample_valid(sample_valid)
);
